// ==== rtl/mseq_defs.svh ====
`ifndef MSEQ_DEFS_SVH
`define MSEQ_DEFS_SVH

// Microcode address width, full CGA range
`define MSEQ_AW 13

// Control store words; upper address bits wrap into this
`define MSEQ_DEPTH 64

// Return stack entries, nesting limit for calls
`define MSEQ_STACK_DEPTH 4

`endif

// ==== rtl/mseq_pkg.sv ====
`include "mseq_defs.svh"

package mseq_pkg;

  // Next-address source, same order as the four-way mux
  typedef enum logic [1:0] {
    sel_jump   = 2'd0,  // Jump or dispatch target
    sel_return = 2'd1,  // Top of return stack
    sel_next   = 2'd2,  // Current address plus one
    sel_repeat = 2'd3   // Current address again
  } mseq_sel_e;

  typedef enum logic [2:0] {
    op_cont     = 3'd0,  // Fall through
    op_jump     = 3'd1,  // Go to {page, target}
    op_dispatch = 3'd2,  // Low nibble from jmp_lo
    op_call     = 3'd3,  // Push return, then jump
    op_ret      = 3'd4,  // Pop return address
    op_repeat   = 3'd5,  // Reissue rep_count times
    op_halt     = 3'd6   // Stop sequencing
  } mseq_op_e;

  typedef struct packed {
    mseq_op_e    op;
    logic        page;    // Address bit 12
    logic [11:0] target;  // Address bits 11:0
    logic [7:0]  ctrl;    // Opaque control payload
  } micro_word_t;

  typedef struct packed {
    logic [`MSEQ_AW-1:0] addr;  // Address the word was read from
    micro_word_t         word;
  } mseq_out_t;

  typedef enum logic [2:0] {
    cfg_store_write = 3'd0,
    cfg_set_start   = 3'd1,
    cfg_set_repeat  = 3'd2,
    cfg_run         = 3'd3,
    cfg_halt        = 3'd4
  } cfg_kind_e;

  typedef struct packed {
    cfg_kind_e           kind;
    logic [`MSEQ_AW-1:0] addr;  // Store address or start vector
    logic [23:0]         data;  // Microword or repeat count
  } cfg_req_t;

endpackage

// ==== rtl/maddr_select.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module maddr_select import mseq_pkg::*; (
  input  logic                sysclk,
  input  logic                sys_rst_n,
  input  mseq_sel_e           sel,         // Source for the next address
  input  logic                step,        // Advance allowed this cycle
  input  logic                load_start,  // Force start vector
  input  logic [`MSEQ_AW-1:0] start_addr,
  input  logic [`MSEQ_AW-1:0] jump_addr,
  input  logic [`MSEQ_AW-1:0] ret_addr,
  output logic [`MSEQ_AW-1:0] next_addr,   // Also the store read address
  output logic [`MSEQ_AW-1:0] cur_addr,
  output logic [`MSEQ_AW-1:0] inc_addr
);

  logic [`MSEQ_AW-1:0] mux_addr;  // Four-way select result

  assign inc_addr = cur_addr + 1'b1;  // Wraps at top of address space

  always_comb begin
    unique case (sel)
      sel_jump:   mux_addr = jump_addr;
      sel_return: mux_addr = ret_addr;
      sel_next:   mux_addr = inc_addr;
      sel_repeat: mux_addr = cur_addr;
      default:    mux_addr = cur_addr;
    endcase
  end

  // Start vector wins over the mux; a stall holds the address so the
  // synchronous store read keeps returning the same word
  always_comb begin
    if (load_start) begin
      next_addr = start_addr;
    end else if (step) begin
      next_addr = mux_addr;
    end else begin
      next_addr = cur_addr;  // Stalled
    end
  end

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      cur_addr <= '0;
    end else if (step || load_start) begin
      cur_addr <= next_addr;  // Same edge as the store read
    end
  end

endmodule

// ==== rtl/return_stack.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module return_stack (
  input  logic                sysclk,
  input  logic                sys_rst_n,
  input  logic                push,
  input  logic                pop,
  input  logic [`MSEQ_AW-1:0] push_addr,  // Return address, call site plus one
  output logic [`MSEQ_AW-1:0] ret_addr,   // Always the top entry
  output logic                empty
);

  localparam int PW = $clog2(`MSEQ_STACK_DEPTH);

  logic [`MSEQ_AW-1:0] mem [`MSEQ_STACK_DEPTH];
  logic [PW:0]         ptr;      // Entry count, one extra bit for full
  logic [PW-1:0]       top_idx;
  logic                full;

  assign empty    = (ptr == '0);
  assign full     = (ptr == (PW+1)'(`MSEQ_STACK_DEPTH));
  assign top_idx  = ptr[PW-1:0] - 1'b1;  // Slot below the pointer
  assign ret_addr = mem[top_idx];

  always_ff @(posedge sysclk) begin
    if (push && !full) begin
      mem[ptr[PW-1:0]] <= push_addr;
    end
  end

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      ptr <= '0;
    end else if (push && !full) begin
      ptr <= ptr + 1'b1;
    end else if (pop && !empty) begin
      ptr <= ptr - 1'b1;
    end
  end

  // Call nesting deeper than the stack
  a_no_overflow: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    push |-> !full) else $error("return_stack push while full");

  // Return without matching call
  a_no_underflow: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    pop |-> !empty) else $error("return_stack pop while empty");

endmodule

// ==== rtl/control_store.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module control_store import mseq_pkg::*; (
  input  logic                sysclk,
  input  logic [`MSEQ_AW-1:0] rd_addr,  // Selected next address
  output micro_word_t         rd_word,  // Lines up with cur_addr
  input  logic                we,
  input  logic [`MSEQ_AW-1:0] waddr,
  input  micro_word_t         wdata
);

  localparam int IW = $clog2(`MSEQ_DEPTH);

  micro_word_t       mem [`MSEQ_DEPTH];
  logic [IW-1:0]     rd_idx;
  logic [IW-1:0]     wr_idx;

  // Only the low bits decode, high bits alias
  assign rd_idx = rd_addr[IW-1:0];
  assign wr_idx = waddr[IW-1:0];

  always_ff @(posedge sysclk) begin
    if (we) begin
      mem[wr_idx] <= wdata;  // Loader port, idle while running
    end
  end

  always_ff @(posedge sysclk) begin
    rd_word <= mem[rd_idx];  // Read-first on a same-address write
  end

endmodule

// ==== rtl/mseq_cfg.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module mseq_cfg import mseq_pkg::*; (
  input  logic                sysclk,
  input  logic                sys_rst_n,
  input  logic                cfg_valid,
  output logic                cfg_ready,
  input  cfg_req_t            cfg_req,
  input  logic                running,      // Sequencer out of idle
  output logic                run_pulse,
  output logic                halt_req,
  output logic [`MSEQ_AW-1:0] start_addr,
  output logic [`MSEQ_AW-1:0] rep_count,
  output logic                store_we,
  output logic [`MSEQ_AW-1:0] store_waddr,
  output micro_word_t         store_wdata
);

  logic accept;

  // A run pulse in flight counts as running before the FSM leaves idle
  assign cfg_ready = !((cfg_req.kind == cfg_store_write) && (running || run_pulse));
  assign accept    = cfg_valid && cfg_ready;

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      run_pulse  <= 1'b0;
      halt_req   <= 1'b0;
      store_we   <= 1'b0;
      start_addr <= '0;
      rep_count  <= `MSEQ_AW'(1);  // Single issue by default
    end else begin
      run_pulse <= accept && (cfg_req.kind == cfg_run);   // One cycle strobes
      halt_req  <= accept && (cfg_req.kind == cfg_halt);
      store_we  <= accept && (cfg_req.kind == cfg_store_write);
      if (accept && (cfg_req.kind == cfg_set_start)) begin
        start_addr <= cfg_req.addr;
      end
      if (accept && (cfg_req.kind == cfg_set_repeat)) begin
        rep_count <= cfg_req.data[`MSEQ_AW-1:0];  // Low bits of data
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (accept) begin
      store_waddr <= cfg_req.addr;
      store_wdata <= micro_word_t'(cfg_req.data);
    end
  end

endmodule

// ==== rtl/mseq_ctrl.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module mseq_ctrl import mseq_pkg::*; (
  input  logic                sysclk,
  input  logic                sys_rst_n,
  input  logic                run_pulse,
  input  logic                halt_req,
  input  logic [`MSEQ_AW-1:0] rep_count,
  input  logic [3:0]          jmp_lo,       // Dispatch nibble
  input  micro_word_t         rd_word,      // Word being issued
  input  logic [`MSEQ_AW-1:0] cur_addr,
  input  logic                stack_empty,
  output mseq_sel_e           sel,
  output logic                step,
  output logic                load_start,
  output logic [`MSEQ_AW-1:0] jump_addr,
  output logic                push,
  output logic                pop,
  output logic                out_valid,
  input  logic                out_ready,
  output mseq_out_t           out_data,
  output logic                running
);

  typedef enum logic [1:0] {
    st_idle  = 2'd0,  // Halted
    st_fetch = 2'd1,  // Start vector read
    st_issue = 2'd2   // Word on the output stream
  } state_e;

  state_e              state;
  logic                xfer;        // Word accepted downstream
  logic                rep_active;  // Inside a repeat run
  logic [`MSEQ_AW-1:0] rep_left;    // Issues still owed including this one
  logic [`MSEQ_AW-1:0] rep_eff;
  logic                rep_more;
  logic                is_halt;

  assign out_valid  = (state == st_issue);
  assign xfer       = out_valid && out_ready;
  assign step       = xfer || !out_valid;
  assign load_start = (state == st_fetch);
  assign running    = (state != st_idle);
  assign out_data   = '{addr: cur_addr, word: rd_word};  // Read aligned with cur_addr
  assign is_halt    = (rd_word.op == op_halt);

  assign rep_eff  = rep_active ? rep_left : rep_count;
  assign rep_more = (rep_eff > `MSEQ_AW'(1));  // Count of 0 acts as 1

  // Dispatch replaces the low nibble with jmp_lo
  assign jump_addr = (rd_word.op == op_dispatch) ?
                     {rd_word.page, rd_word.target[11:4], jmp_lo} :
                     {rd_word.page, rd_word.target};

  always_comb begin
    sel  = sel_repeat;  // Hold when nothing is issued
    push = 1'b0;
    pop  = 1'b0;
    if (out_valid) begin
      unique case (rd_word.op)
        op_cont:     sel = sel_next;
        op_jump:     sel = sel_jump;
        op_dispatch: sel = sel_jump;
        op_call: begin
          sel  = sel_jump;
          push = xfer;  // inc_addr goes on the stack
        end
        op_ret: begin
          sel = stack_empty ? sel_next : sel_return;  // Stray return falls through
          pop = xfer;  // Empty pop flagged by the stack
        end
        op_repeat:   sel = rep_more ? sel_repeat : sel_next;
        op_halt:     sel = sel_repeat;
        default:     sel = sel_next;  // Unused code
      endcase
    end
  end

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      state      <= st_idle;
      rep_active <= 1'b0;
      rep_left   <= '0;
    end else begin
      unique case (state)
        st_idle:  if (run_pulse) state <= st_fetch;
        st_fetch: state <= halt_req ? st_idle : st_issue;
        st_issue: if (halt_req || (xfer && is_halt)) state <= st_idle;
        default:  state <= st_idle;
      endcase
      if (state != st_issue) begin
        rep_active <= 1'b0;  // Fresh count on every run
      end else if (xfer && (rd_word.op == op_repeat)) begin
        rep_active <= rep_more;
        rep_left   <= rep_eff - 1'b1;
      end
    end
  end

  // Stall must freeze address register and store read together
  a_out_stable: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    out_valid && !out_ready && !halt_req |=> out_valid && $stable(out_data))
    else $error("out_data changed under back-pressure");

endmodule

// ==== rtl/microsequencer.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module microsequencer import mseq_pkg::*; (
  input  logic       sysclk,
  input  logic       sys_rst_n,
  input  logic       cfg_valid,
  output logic       cfg_ready,
  input  cfg_req_t   cfg_req,
  output logic       out_valid,
  input  logic       out_ready,
  output mseq_out_t  out_data,
  input  logic [3:0] jmp_lo,
  output logic       halted
);

  logic                run_pulse;
  logic                halt_req;
  logic [`MSEQ_AW-1:0] start_addr;
  logic [`MSEQ_AW-1:0] rep_count;
  logic                store_we;
  logic [`MSEQ_AW-1:0] store_waddr;
  micro_word_t         store_wdata;
  micro_word_t         rd_word;
  mseq_sel_e           sel;
  logic                step;
  logic                load_start;
  logic                running;
  logic                push;
  logic                pop;
  logic                stack_empty;
  logic [`MSEQ_AW-1:0] jump_addr;
  logic [`MSEQ_AW-1:0] ret_addr;
  logic [`MSEQ_AW-1:0] next_addr;
  logic [`MSEQ_AW-1:0] cur_addr;
  logic [`MSEQ_AW-1:0] inc_addr;

  assign halted = !running;  // High out of reset

  mseq_cfg i_mseq_cfg (
    .sysclk, .sys_rst_n, .cfg_valid, .cfg_ready, .cfg_req, .running,
    .run_pulse, .halt_req, .start_addr, .rep_count,
    .store_we, .store_waddr, .store_wdata
  );

  mseq_ctrl i_mseq_ctrl (
    .sysclk, .sys_rst_n, .run_pulse, .halt_req, .rep_count, .jmp_lo,
    .rd_word, .cur_addr, .stack_empty, .sel, .step, .load_start, .jump_addr,
    .push, .pop, .out_valid, .out_ready, .out_data, .running
  );

  maddr_select i_maddr_select (
    .sysclk, .sys_rst_n, .sel, .step, .load_start, .start_addr, .jump_addr,
    .ret_addr, .next_addr, .cur_addr, .inc_addr
  );

  return_stack i_return_stack (
    .sysclk, .sys_rst_n, .push, .pop,
    .push_addr (inc_addr),  // Call site plus one
    .ret_addr, .empty (stack_empty)
  );

  control_store i_control_store (
    .sysclk,
    .rd_addr (next_addr),  // Read lands with cur_addr
    .rd_word,
    .we      (store_we),
    .waddr   (store_waddr),
    .wdata   (store_wdata)
  );

endmodule

// ==== tests/tb_microsequencer.sv ====
`timescale 1ns/1ps
`include "mseq_defs.svh"

module tb_microsequencer import mseq_pkg::*; ();

  localparam int IW        = $clog2(`MSEQ_DEPTH);
  localparam int NUM_TESTS = 6;

  logic                sysclk;
  logic                sys_rst_n;
  logic                cfg_valid;
  logic                cfg_ready;
  cfg_req_t            cfg_req;
  logic                out_valid;
  logic                out_ready;
  mseq_out_t           out_data;
  logic [3:0]          jmp_lo;
  logic                halted;

  micro_word_t         prog [`MSEQ_DEPTH];  // Image of the control store
  micro_word_t         exp_word;
  logic [`MSEQ_AW-1:0] exp_addr;            // Predicted address of next transfer
  logic [`MSEQ_AW-1:0] model_start;
  logic [`MSEQ_AW-1:0] model_rep;
  logic [`MSEQ_AW-1:0] rep_done;            // Issues of current repeat word
  logic [`MSEQ_AW-1:0] ret_q [$];           // Model return stack
  logic [2:0]          run_d;               // Run accept delay line
  logic                xfer;
  logic                stall_on;
  int                  xfer_cnt;
  int                  run_base;
  int                  errors    = 0;
  int                  err_base  = 0;
  int                  tests_run = 0;
  int                  tests_ok  = 0;

  microsequencer i_microsequencer (
    .sysclk, .sys_rst_n, .cfg_valid, .cfg_ready, .cfg_req,
    .out_valid, .out_ready, .out_data, .jmp_lo, .halted
  );

  initial begin : clock_gen
    sysclk = 1'b0;
    forever #50 sysclk = ~sysclk;
  end

  assign xfer     = out_valid && out_ready;
  assign exp_word = prog[exp_addr[IW-1:0]];  // High bits alias like the store

  always @(posedge sysclk) begin : ref_model
    logic [`MSEQ_AW-1:0] nxt;
    nxt = exp_addr;
    if (!sys_rst_n) begin
      exp_addr    <= '0;
      rep_done    <= '0;
      run_d       <= '0;
      xfer_cnt    <= 0;
      model_start <= '0;
      model_rep   <= `MSEQ_AW'(1);
      ret_q.delete();
    end else begin
      run_d <= {run_d[1:0], cfg_valid && cfg_ready && (cfg_req.kind == cfg_run)};
      if (cfg_valid && cfg_ready) begin
        case (cfg_req.kind)
          cfg_set_start:  model_start <= cfg_req.addr;
          cfg_set_repeat: model_rep <= cfg_req.data[`MSEQ_AW-1:0];
          cfg_run: begin
            nxt      = model_start;  // Fresh run starts with an empty stack
            rep_done <= '0;
            ret_q.delete();
          end
          default: ;
        endcase
      end
      if (xfer) begin
        xfer_cnt <= xfer_cnt + 1;
        case (exp_word.op)
          op_cont:     nxt = exp_addr + 1'b1;
          op_jump:     nxt = {exp_word.page, exp_word.target};
          op_dispatch: nxt = {exp_word.page, exp_word.target[11:4], jmp_lo};
          op_call: begin
            ret_q.push_back(exp_addr + 1'b1);
            nxt = {exp_word.page, exp_word.target};
          end
          op_ret:      nxt = ret_q.pop_back();
          op_repeat: begin
            if (rep_done + 1'b1 >= model_rep) begin  // Last issue of the run
              rep_done <= '0;
              nxt      = exp_addr + 1'b1;
            end else begin
              rep_done <= rep_done + 1'b1;
            end
          end
          default:     nxt = exp_addr;  // Halt stays put
        endcase
      end
      exp_addr <= nxt;
    end
  end

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  a_reset_state: assert property (@(posedge sysclk) !sys_rst_n |=> !out_valid && halted)
    else flag_mismatch("outputs not idle after reset");
  a_first_addr: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    run_d[2] |-> out_valid && (out_data.addr == model_start))
    else flag_mismatch("first word not at the start vector");
  a_addr: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    xfer |-> out_data.addr == exp_addr) else flag_mismatch("transferred address");
  a_word: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    xfer |-> out_data.word == exp_word) else flag_mismatch("transferred microword");
  a_stable: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else flag_mismatch("out_data moved while stalled");
  a_halt: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    xfer && (exp_word.op == op_halt) |=> halted && !out_valid)
    else flag_mismatch("no halt after op_halt");
  a_idle: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    halted |-> !out_valid) else flag_mismatch("word valid while halted");
  a_refuse: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    !halted && cfg_valid && (cfg_req.kind == cfg_store_write) |-> !cfg_ready)
    else flag_mismatch("store write ready while running");
  a_accept: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    halted && !run_d[0] && cfg_valid && (cfg_req.kind == cfg_store_write) |-> cfg_ready)
    else flag_mismatch("store write refused while halted");

  function automatic micro_word_t make_word(input int idx, input mseq_op_e op,
                                            input logic page, input logic [11:0] target);
    return '{op: op, page: page, target: target, ctrl: 8'(idx * 29 + 7)};
  endfunction

  // Starts at a falling edge and returns at the falling edge after acceptance
  task automatic send_cfg(input cfg_kind_e kind, input logic [`MSEQ_AW-1:0] addr,
                          input logic [23:0] data);
    int waits;
    waits     = 0;
    cfg_req   = '{kind: kind, addr: addr, data: data};
    cfg_valid = 1'b1;
    #1;
    while (!cfg_ready && waits < 50) begin
      @(negedge sysclk);
      #1;
      waits++;
    end
    if (!cfg_ready) begin
      errors++;
      $display("Config request %s was never accepted", kind.name());
    end
    @(negedge sysclk);  // Taken on the rising edge in between
    cfg_valid = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < `MSEQ_DEPTH; i++) begin
      prog[i] = make_word(i, op_halt, 1'b0, 12'(i * 5));  // Halt everywhere else
    end
    prog[0]  = make_word(0, op_call, 1'b0, 12'd10);   // Outer call
    prog[5]  = make_word(5, op_cont, 1'b0, 12'd0);
    prog[8]  = make_word(8, op_cont, 1'b0, 12'd0);
    prog[9]  = make_word(9, op_jump, 1'b0, 12'd20);
    prog[10] = make_word(10, op_call, 1'b0, 12'd15);  // Inner call
    prog[11] = make_word(11, op_ret, 1'b0, 12'd0);
    prog[15] = make_word(15, op_cont, 1'b0, 12'd0);
    prog[16] = make_word(16, op_ret, 1'b0, 12'd0);
    prog[20] = make_word(20, op_dispatch, 1'b0, 12'h020);  // Table at 32..47
    prog[24] = make_word(24, op_cont, 1'b0, 12'd0);
    prog[25] = make_word(25, op_repeat, 1'b0, 12'd0);
    prog[50] = make_word(50, op_jump, 1'b1, 12'd52);  // Page 1 target aliasing to 52
    prog[60] = make_word(60, op_repeat, 1'b0, 12'd0);
    for (int i = 32; i < 48; i++) begin
      prog[i] = make_word(i, op_jump, 1'b0, 12'd50);
    end
    for (int i = 0; i < `MSEQ_DEPTH; i++) begin
      send_cfg(cfg_store_write, `MSEQ_AW'(i), prog[i]);
    end
  endtask

  task automatic start_run(input logic [`MSEQ_AW-1:0] start, input logic [`MSEQ_AW-1:0] reps);
    send_cfg(cfg_set_start, start, 24'd0);
    send_cfg(cfg_set_repeat, '0, 24'(reps));
    run_base = xfer_cnt;
    send_cfg(cfg_run, '0, 24'd0);
  endtask

  task automatic wait_halt(input int exp_n);
    int waits;
    waits = 0;
    while (halted && waits < 10) begin  // Run not yet out of idle
      @(negedge sysclk);
      waits++;
    end
    while (!halted && waits < 150) begin
      @(negedge sysclk);
      waits++;
    end
    if (!halted) begin
      errors++;
      $display("Sequencer did not halt within %0d cycles", waits);
    end
    @(negedge sysclk);  // Post-halt check samples on this edge
    assert (xfer_cnt - run_base == exp_n)
      else flag_mismatch($sformatf("%0d words transferred, expected %0d",
                                   xfer_cnt - run_base, exp_n));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_base) begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_base);
    end
    err_base = errors;
  endtask

  initial begin : drive_stream
    void'($urandom(32'h9323_737b));
    out_ready = 1'b1;
    jmp_lo    = 4'h0;
    forever begin
      @(negedge sysclk);
      out_ready = stall_on ? (($urandom % 3) != 0) : 1'b1;  // About one stall in three
      jmp_lo    = 4'($urandom);
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * 200) @(posedge sysclk);
    $display("Watchdog expired before the tests completed");
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    sys_rst_n = 1'b0;
    cfg_valid = 1'b0;
    cfg_req   = '0;
    stall_on  = 1'b0;
    repeat (4) @(posedge sysclk);
    @(negedge sysclk);
    sys_rst_n = 1'b1;
    load_program();
    start_run(`MSEQ_AW'(5), `MSEQ_AW'(1));
    wait_halt(2);
    end_test("reset and start vector");
    start_run(`MSEQ_AW'(8), `MSEQ_AW'(1));  // Cont, jump, dispatch, page jump
    wait_halt(6);
    end_test("cont jump dispatch");
    start_run(`MSEQ_AW'(0), `MSEQ_AW'(1));
    wait_halt(6);
    end_test("nested call return");
    start_run(`MSEQ_AW'(24), `MSEQ_AW'(4));
    wait_halt(6);
    end_test("repeat");
    stall_on = 1'b1;
    start_run(`MSEQ_AW'(0), `MSEQ_AW'(1));
    wait_halt(6);
    start_run(`MSEQ_AW'(8), `MSEQ_AW'(1));
    wait_halt(6);
    stall_on = 1'b0;
    end_test("back-pressure");
    start_run(`MSEQ_AW'(60), `MSEQ_AW'(10));
    cfg_req   = '{kind: cfg_store_write, addr: `MSEQ_AW'(60), data: 24'hfff000};
    cfg_valid = 1'b1;  // Would corrupt the running word
    repeat (3) @(negedge sysclk);
    cfg_valid = 1'b0;
    wait_halt(11);
    prog[63] = make_word(63, op_cont, 1'b0, 12'd0);
    send_cfg(cfg_store_write, `MSEQ_AW'(63), prog[63]);
    end_test("halt and store lock");
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_ok, tests_run - tests_ok, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== microsequencer.f ====
+incdir+rtl
rtl/mseq_pkg.sv
rtl/maddr_select.sv
rtl/return_stack.sv
rtl/control_store.sv
rtl/mseq_cfg.sv
rtl/mseq_ctrl.sv
rtl/microsequencer.sv
tests/tb_microsequencer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the microsequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_microsequencer \
  -f microsequencer.f -o sim_microsequencer || exit 1
out=$(./obj_dir/sim_microsequencer)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && echo "simulation passed" && exit 0 || \
  { echo "simulation failed"; exit 1; }
